// File: build.f
+incdir+include
source/rv_isa_pkg.sv
source/mem_bus_pkg.sv
source/c_expander.sv
source/if_stage.sv
source/mem_port_arbiter.sv
source/instr_mem.sv
source/fetch_top.sv
verification/fetch_tb.sv

// File: include/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// reset pc
`define BOOT_ADDR 32'h0000_0000

// instruction memory depth in 32-bit words
`define IMEM_WORDS 64

// add x0, x0, x0
`define NOP_INSTR 32'h0000_0033

`endif

// File: source/c_expander.sv
`include "fetch_params.svh"

module c_expander
    import rv_isa_pkg::*;
(
    input  fetch_word_u instr_i,
    output logic        compressed_o,
    output logic [31:0] instr_o,
    output logic        illegal_o
);

    logic [15:0] c;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] ci_imm;

    assign c      = instr_i.parcel.lo;
    assign rd     = c[11:7];
    assign rs2    = c[6:2];
    assign ci_imm = {{6{c[12]}}, c[12], c[6:2]};  // ci format, sign extended

    assign compressed_o = (c[1:0] != 2'b11);

    always_comb begin
        instr_o   = instr_i.word;
        illegal_o = 1'b0;
        if (compressed_o) begin
            instr_o   = `NOP_INSTR;  // default for anything unsupported
            illegal_o = 1'b1;
            case ({c[1:0], c[15:13]})
                5'b01_000: begin  // c.addi
                    instr_o   = {ci_imm, rd, 3'b000, rd, OP_IMM};
                    illegal_o = 1'b0;
                end
                5'b01_010: begin  // c.li
                    instr_o   = {ci_imm, 5'd0, 3'b000, rd, OP_IMM};
                    illegal_o = 1'b0;
                end
                5'b01_011: begin
                    // rd == 2 is c.addi16sp, zero imm is reserved
                    if (rd != 5'd2 && {c[12], c[6:2]} != 6'd0) begin
                        instr_o   = {{14{c[12]}}, c[12], c[6:2], rd, LUI};
                        illegal_o = 1'b0;
                    end
                end
                5'b01_101: begin  // c.j -> jal x0
                    instr_o   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                 c[12], {8{c[12]}}, 5'd0, JAL};
                    illegal_o = 1'b0;
                end
                5'b10_100: begin
                    // rs2 == 0 would be c.jr / c.jalr / c.ebreak
                    if (rs2 != 5'd0) begin
                        if (c[12]) begin
                            instr_o = {7'd0, rs2, rd, 3'b000, rd, OP};    // c.add
                        end else begin
                            instr_o = {7'd0, rs2, 5'd0, 3'b000, rd, OP};  // c.mv
                        end
                        illegal_o = 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: source/fetch_top.sv
module fetch_top
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fetch_en_i,
    input  logic        stall_i,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    input  mem_req_t    host_req_i,
    output mem_rsp_t    host_rsp_o,
    output ifid_t       ifid_o
);

    mem_req_t    fetch_req;
    mem_rsp_t    fetch_rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    fetch_word_u raw_instr;
    logic [31:0] exp_instr;
    logic        exp_compressed;
    logic        exp_illegal;

    if_stage u_if_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_en_i       (fetch_en_i),
        .stall_i          (stall_i),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .bus_req_o        (fetch_req),
        .bus_rsp_i        (fetch_rsp),
        .raw_instr_o      (raw_instr),
        .exp_instr_i      (exp_instr),
        .exp_compressed_i (exp_compressed),
        .exp_illegal_i    (exp_illegal),
        .ifid_o           (ifid_o)
    );

    c_expander u_c_expander (
        .instr_i      (raw_instr),
        .compressed_o (exp_compressed),
        .instr_o      (exp_instr),
        .illegal_o    (exp_illegal)
    );

    mem_port_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req_i (fetch_req),
        .host_req_i  (host_req_i),
        .fetch_rsp_o (fetch_rsp),
        .host_rsp_o  (host_rsp_o),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

    instr_mem u_instr_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

endmodule

// File: source/if_stage.sv
`include "fetch_params.svh"

module if_stage
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fetch_en_i,
    input  logic        stall_i,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    output mem_req_t    bus_req_o,
    input  mem_rsp_t    bus_rsp_i,
    output fetch_word_u raw_instr_o,
    input  logic [31:0] exp_instr_i,
    input  logic        exp_compressed_i,
    input  logic        exp_illegal_i,
    output ifid_t       ifid_o
);

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_WAIT_ACK,
        BUS_WAIT_LOW
    } bus_state_e;

    bus_state_e  bus_state_q;
    logic [31:0] fetch_addr_q;
    logic        discard_q;     // redirect hit an open cycle

    logic [31:0] pc_q;
    fetch_word_u buf_q;
    logic [29:0] buf_addr_q;
    logic        buf_valid_q;
    logic [15:0] carry_q;       // low half of a 32-bit instr at pc[1]=1
    logic        carry_valid_q;
    ifid_t       ifid_q;

    logic [29:0] need_addr;
    logic        have_word;
    logic        hi_is_wide;
    logic        cand_valid;
    logic        take;
    logic        fetch_start;
    logic        buf_load;
    logic        carry_load;

    assign need_addr   = carry_valid_q ? pc_q[31:2] + 30'd1 : pc_q[31:2];
    assign have_word   = buf_valid_q && (buf_addr_q == need_addr);
    assign hi_is_wide  = (buf_q.parcel.hi[1:0] == 2'b11);
    assign cand_valid  = have_word && (carry_valid_q || !pc_q[1] || !hi_is_wide);
    assign take        = cand_valid && !stall_i && !redirect_i;
    assign carry_load  = have_word && pc_q[1] && !carry_valid_q && hi_is_wide && !redirect_i;
    assign fetch_start = (bus_state_q == BUS_IDLE) && fetch_en_i && !have_word && !redirect_i;
    assign buf_load    = (bus_state_q == BUS_WAIT_ACK) && bus_rsp_i.ack && !discard_q &&
                         !redirect_i;

    // candidate instruction at pc
    always_comb begin
        raw_instr_o = buf_q;
        if (carry_valid_q) begin
            raw_instr_o.parcel.hi = buf_q.parcel.lo;
            raw_instr_o.parcel.lo = carry_q;
        end else if (pc_q[1]) begin
            raw_instr_o.parcel.hi = 16'h0000;
            raw_instr_o.parcel.lo = buf_q.parcel.hi;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_state_q <= BUS_IDLE;
            discard_q   <= 1'b0;
        end else begin
            case (bus_state_q)
                BUS_IDLE: begin
                    discard_q <= 1'b0;
                    if (fetch_start) begin
                        bus_state_q <= BUS_WAIT_ACK;
                    end
                end
                BUS_WAIT_ACK: begin
                    if (redirect_i) begin
                        discard_q <= 1'b1;
                    end
                    if (bus_rsp_i.ack) begin
                        bus_state_q <= BUS_WAIT_LOW;  // drop req
                    end
                end
                BUS_WAIT_LOW: begin
                    if (!bus_rsp_i.ack) begin
                        bus_state_q <= BUS_IDLE;
                    end
                end
                default: bus_state_q <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start) begin
            fetch_addr_q <= {need_addr, 2'b00};
        end
        if (buf_load) begin
            buf_q.word <= bus_rsp_i.rdata;
            buf_addr_q <= fetch_addr_q[31:2];
        end
        if (carry_load) begin
            carry_q <= buf_q.parcel.hi;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q          <= `BOOT_ADDR;
            buf_valid_q   <= 1'b0;
            carry_valid_q <= 1'b0;
            ifid_q        <= '{valid: 1'b0, pc: `BOOT_ADDR, ir: `NOP_INSTR, illegal: 1'b0};
        end else if (redirect_i) begin  // wins over stall
            pc_q           <= redirect_pc_i;
            buf_valid_q    <= 1'b0;
            carry_valid_q  <= 1'b0;
            ifid_q.valid   <= 1'b0;
            ifid_q.ir      <= `NOP_INSTR;
            ifid_q.illegal <= 1'b0;
        end else begin
            if (buf_load) begin
                buf_valid_q <= 1'b1;
            end
            if (carry_load) begin
                carry_valid_q <= 1'b1;
            end
            if (!stall_i) begin
                ifid_q.valid   <= cand_valid;
                ifid_q.pc      <= pc_q;
                ifid_q.ir      <= cand_valid ? exp_instr_i : `NOP_INSTR;
                ifid_q.illegal <= cand_valid && exp_illegal_i;
            end
            if (take) begin
                pc_q          <= pc_q + (exp_compressed_i ? 32'd2 : 32'd4);
                carry_valid_q <= 1'b0;
            end
        end
    end

    assign bus_req_o = '{req:   (bus_state_q == BUS_WAIT_ACK),
                         we:    1'b0,
                         addr:  fetch_addr_q,
                         wdata: 32'h0000_0000};
    assign ifid_o    = ifid_q;

endmodule

// File: source/instr_mem.sv
`include "fetch_params.svh"

module instr_mem
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t req_i,
    output mem_rsp_t rsp_o
);

    localparam int AW = $clog2(`IMEM_WORDS);

    logic [31:0]   mem_q [`IMEM_WORDS];
    logic [31:0]   rdata_q;
    logic          ack_q;
    logic [AW-1:0] word_idx;

    assign word_idx = req_i.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_i.req;  // follows req by one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.req && !ack_q) begin
            if (req_i.we) begin
                mem_q[word_idx] <= req_i.wdata;
            end
            rdata_q <= mem_q[word_idx];
        end
    end

    assign rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

// File: source/mem_bus_pkg.sv
package mem_bus_pkg;

    // four-phase request, fields held while req is high
    typedef struct packed {
        logic        req;
        logic        we;
        logic [31:0] addr;   // byte address
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;  // valid while ack high
    } mem_rsp_t;

    typedef enum logic {
        PORT_FETCH = 1'b0,
        PORT_HOST  = 1'b1
    } port_e;

endpackage

// File: source/mem_port_arbiter.sv
module mem_port_arbiter
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t fetch_req_i,
    input  mem_req_t host_req_i,
    output mem_rsp_t fetch_rsp_o,
    output mem_rsp_t host_rsp_o,
    output mem_req_t mem_req_o,
    input  mem_rsp_t mem_rsp_i
);

    port_e owner_q;
    logic  busy_q;
    port_e owner;

    // host first when idle
    assign owner     = busy_q ? owner_q : (host_req_i.req ? PORT_HOST : PORT_FETCH);
    assign mem_req_o = (owner == PORT_HOST) ? host_req_i : fetch_req_i;

    always_comb begin
        fetch_rsp_o = '{ack: 1'b0, rdata: mem_rsp_i.rdata};
        host_rsp_o  = '{ack: 1'b0, rdata: mem_rsp_i.rdata};
        if (owner == PORT_HOST) begin
            host_rsp_o.ack = mem_rsp_i.ack;
        end else begin
            fetch_rsp_o.ack = mem_rsp_i.ack;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            owner_q <= PORT_FETCH;
        end else if (!busy_q) begin
            if (mem_req_o.req) begin
                busy_q  <= 1'b1;
                owner_q <= owner;
            end
        end else if (!mem_req_o.req && !mem_rsp_i.ack) begin
            busy_q <= 1'b0;  // four-phase cycle done
        end
    end

endmodule

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

    // one fetched word, read whole or as two parcels
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [15:0] hi;
            logic [15:0] lo;
        } parcel;
    } fetch_word_u;

    // major opcodes produced by the compressed expander
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111
    } opcode_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] ir;
        logic        illegal;  // unsupported compressed encoding
    } ifid_t;

endpackage

// File: verification/fetch_tb.sv
`include "fetch_params.svh"

module fetch_tb
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam string VEC_FILE   = "verification/fetch_vectors.txt";
    localparam int    ACK_LIMIT  = 20;
    localparam int    IDLE_LIMIT = 200;

    logic        clk;
    logic        rst_n;
    logic        fetch_en;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    mem_req_t    host_req;
    mem_rsp_t    host_rsp;
    ifid_t       ifid;
    integer      seed;

    logic [31:0] m_addr_q[$];
    logic [31:0] m_data_q[$];
    int          j_count_q[$];
    logic [31:0] j_target_q[$];
    ifid_t       exp_q[$];

    fetch_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_en_i    (fetch_en),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .host_req_i    (host_req),
        .host_rsp_o    (host_rsp),
        .ifid_o        (ifid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic read_vectors();
        int           fd;
        int           code;
        int           n;
        logic [7:0]   kind;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [1023:0] line;
        ifid_t        e;
        bit           done;
        fd = $fopen(VEC_FILE, "r");
        assert (fd != 0) else report_failure("could not open the vector file");
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(line, fd);  // skip comment
            end else if (kind == "M") begin
                code = $fscanf(fd, "%h %h", a, b);
                assert (code == 2) else report_failure("malformed memory line in the vector file");
                m_addr_q.push_back(a);
                m_data_q.push_back(b);
            end else if (kind == "J") begin
                code = $fscanf(fd, "%d %h", n, a);
                assert (code == 2) else report_failure("malformed redirect line in the vector file");
                j_count_q.push_back(n);
                j_target_q.push_back(a);
            end else begin
                assert (kind == "E") else report_failure("unknown line type in the vector file");
                code = $fscanf(fd, "%h %h %d", a, b, n);
                assert (code == 3) else report_failure("malformed expect line in the vector file");
                e.valid   = 1'b1;
                e.pc      = a;
                e.ir      = b;
                e.illegal = n[0];
                exp_q.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    task automatic reset_dut();
        rst_n    = 1'b0;
        fetch_en = 1'b0;
        stall    = 1'b0;
        redirect = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        assert (ifid.valid === 1'b0)
            else report_failure($sformatf("Mismatch ifid_o.valid expected 0 got %h", ifid.valid));
        assert (ifid.ir === `NOP_INSTR)
            else report_failure($sformatf("Mismatch ifid_o.ir expected %h got %h",
                                          `NOP_INSTR, ifid.ir));
        assert (ifid.pc === `BOOT_ADDR)
            else report_failure($sformatf("Mismatch ifid_o.pc expected %h got %h",
                                          `BOOT_ADDR, ifid.pc));
        assert (host_rsp.ack === 1'b0)
            else report_failure($sformatf("Mismatch host_rsp_o.ack expected 0 got %h",
                                          host_rsp.ack));
    endtask

    task automatic wait_host_ack(input logic level, input string what);
        int cycles;
        @(negedge clk);
        cycles = 1;
        while (host_rsp.ack !== level) begin
            assert (cycles < ACK_LIMIT) else report_failure(what);
            @(negedge clk);
            cycles++;
        end
    endtask

    // one four-phase cycle on the host port
    task automatic host_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        host_req.we    = we;
        host_req.addr  = addr;
        host_req.wdata = wdata;
        host_req.req   = 1'b1;
        wait_host_ack(1'b1, "timed out waiting for host ack");
        rdata        = host_rsp.rdata;
        host_req.req = 1'b0;
        wait_host_ack(1'b0, "timed out waiting for host ack to drop");
    endtask

    task automatic load_and_verify_memory();
        logic [31:0] rdata;
        int          i;
        for (i = 0; i < m_addr_q.size(); i++) begin
            host_access(1'b1, m_addr_q[i], m_data_q[i], rdata);
        end
        for (i = 0; i < m_addr_q.size(); i++) begin
            host_access(1'b0, m_addr_q[i], 32'h0000_0000, rdata);
            assert (rdata === m_data_q[i])
                else report_failure($sformatf("Mismatch host_rsp_o.rdata expected %h got %h",
                                              m_data_q[i], rdata));
        end
    endtask

    task automatic check_instr(input ifid_t exp);
        assert (ifid.pc === exp.pc)
            else report_failure($sformatf("Mismatch ifid_o.pc expected %h got %h",
                                          exp.pc, ifid.pc));
        assert (ifid.ir === exp.ir)
            else report_failure($sformatf("Mismatch ifid_o.ir expected %h got %h",
                                          exp.ir, ifid.ir));
        assert (ifid.illegal === exp.illegal)
            else report_failure($sformatf("Mismatch ifid_o.illegal expected %h got %h",
                                          exp.illegal, ifid.illegal));
    endtask

    // accept is decided for the next rising edge
    task automatic run_program(input bit use_stall);
        int          idx;
        int          jidx;
        int          idle;
        bit          pending;
        bit          accepted;
        bit          held;
        bit          squashed;
        ifid_t       prev;
        logic [31:0] rnd;
        idx      = 0;
        jidx     = 0;
        idle     = 0;
        pending  = 1'b0;
        held     = 1'b0;
        squashed = 1'b0;
        fetch_en = 1'b1;
        while (idx < exp_q.size()) begin
            @(negedge clk);
            if (held) begin
                assert (ifid === prev)
                    else report_failure($sformatf("Mismatch ifid_o expected %h got %h",
                                                  prev, ifid));
            end
            if (squashed) begin
                assert (ifid.valid === 1'b0)
                    else report_failure($sformatf("Mismatch ifid_o.valid expected 0 got %h",
                                                  ifid.valid));
            end
            rnd      = $random(seed);
            stall    = use_stall && rnd[0];
            redirect = pending;
            if (pending) begin
                redirect_pc = j_target_q[jidx];
                jidx++;
                pending = 1'b0;
            end
            accepted = ifid.valid && !stall && !redirect;  // redirect squashes old path
            if (accepted) begin
                check_instr(exp_q[idx]);
                idx++;
                idle    = 0;
                pending = (jidx < j_count_q.size()) && (idx == j_count_q[jidx]);
            end else begin
                idle++;
                assert (idle < IDLE_LIMIT)
                    else report_failure("timed out waiting for an accepted instruction");
            end
            prev     = ifid;
            held     = stall && !redirect;
            squashed = redirect;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        fetch_en    = 1'b0;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = 32'h0000_0000;
        host_req    = '0;
        seed        = 32'hba936628;
        read_vectors();
        reset_dut();
        load_and_verify_memory();
        run_program(1'b0);  // no back-pressure
        @(negedge clk);
        reset_dut();        // memory keeps the program
        run_program(1'b1);
        @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: verification/fetch_vectors.txt
# M <byte addr> <word>  and  J <accepted count> <redirect target>, all hex except the count
# E <pc> <expected ir> <illegal flag>, listed in acceptance order
M 00000000 00500093
M 00000004 00855175
M 00000008 52B78186
M 0000000C 918A1234
M 00000010 40826205
M 00000014 00428333
M 00000018 0393A025
M 0000001C 00010010
M 00000040 0593451D
M 00000044 862EFFF5
M 00000048 ABCDE6B7
M 0000004C 00200713
M 00000050 16FD0001
M 00000054 87B30040
M 00000058 408100C6
M 0000005C FFFFFFB7
E 00000000 00500093 0
E 00000004 FFD00113 0
E 00000006 00108093 0
E 00000008 001001B3 0
E 0000000A 123452B7 0
E 0000000E 002181B3 0
E 00000010 00001237 0
E 00000012 00000033 1
E 00000014 00428333 0
E 00000018 0280006F 0
J 10 00000040
E 00000040 00700513 0
E 00000042 FFF50593 0
E 00000046 00B00633 0
E 00000048 ABCDE6B7 0
J 14 00000052
E 00000052 FFF68693 0
E 00000054 00000033 1
E 00000056 00C687B3 0
E 0000005A 00000093 0
E 0000005C FFFFFFB7 0
